// File: src/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// datapath widths
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int aluCtrlWidth = 3;

	// first fetch address
	localparam logic [dataWidth-1:0] resetPc = 32'h0000_0000;

	// primary opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opLbu = 6'h24;
	localparam logic [5:0] opSb = 6'h28;
	localparam logic [5:0] opBeq = 6'h04;

	// funct field of R-type words
	localparam logic [5:0] functAddu = 6'h21;
	localparam logic [5:0] functSubu = 6'h23;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr = 6'h25;
	localparam logic [5:0] functSlt = 6'h2a;

	// alu operation select
	localparam logic [aluCtrlWidth-1:0] aluAdd = 3'd0;
	localparam logic [aluCtrlWidth-1:0] aluSub = 3'd1;
	localparam logic [aluCtrlWidth-1:0] aluAnd = 3'd2;
	localparam logic [aluCtrlWidth-1:0] aluOr = 3'd3;
	localparam logic [aluCtrlWidth-1:0] aluSlt = 3'd4;

	// one instruction word, register form or immediate form
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [regAddrWidth-1:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rForm;
		struct packed {
			logic [5:0] op;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [15:0] imm;
		} iForm;
	} instrWord;

endpackage

`default_nettype wire

// File: src/exMemIf.sv
`timescale 1ns/1ns
`default_nettype none

interface exMemIf;
	import mipsPkg::*;

	// control bits, low in a bubble
	logic regWrite;
	logic memToReg;
	logic memWrite;
	// lbu or sb
	logic byteMode;

	// payload
	logic [dataWidth-1:0] aluOut;
	logic [dataWidth-1:0] storeData;
	logic [regAddrWidth-1:0] writeReg;
	logic [dataWidth-1:0] pc;

	// execute side owns the register
	modport exec (
		output regWrite,
		output memToReg,
		output memWrite,
		output byteMode,
		output aluOut,
		output storeData,
		output writeReg,
		output pc
	);

	modport mem (
		input regWrite,
		input memToReg,
		input memWrite,
		input byteMode,
		input aluOut,
		input storeData,
		input writeReg,
		input pc
	);

endinterface

`default_nettype wire

// File: src/instrFetch.sv
`timescale 1ns/1ns
`default_nettype none

module instrFetch (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic redirect,
	input  logic [mipsPkg::dataWidth-1:0] target,
	output logic [mipsPkg::dataWidth-1:0] pc,
	input  mipsPkg::instrWord instr,
	output mipsPkg::instrWord decInstr,
	output logic [mipsPkg::dataWidth-1:0] decPc,
	output logic decValid
);
	import mipsPkg::*;

	logic [dataWidth-1:0] pcPlus4;

	// sequential next address
	assign pcPlus4 = pc + dataWidth'(4);

	// pc and decode slot valid
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
			decValid <= 1'b0;
		end else if (redirect) begin
			// taken beq, drop the word fetched this cycle
			pc <= target;
			decValid <= 1'b0;
		end else if (!stall) begin
			pc <= pcPlus4;
			decValid <= 1'b1;
		end
	end

	// fetch to decode payload
	// held while decode waits on a load
	always_ff @(posedge clk) begin
		if (!stall) begin
			decInstr <= instr;
			decPc <= pc;
		end
	end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  logic clk,
	input  logic [mipsPkg::regAddrWidth-1:0] readA,
	input  logic [mipsPkg::regAddrWidth-1:0] readB,
	output logic [mipsPkg::dataWidth-1:0] dataA,
	output logic [mipsPkg::dataWidth-1:0] dataB,
	input  logic writeEn,
	input  logic [mipsPkg::regAddrWidth-1:0] writeNum,
	input  logic [mipsPkg::dataWidth-1:0] writeData
);
	import mipsPkg::*;

	logic [dataWidth-1:0] regs [32];

	// zero register, then same-cycle write bypass, then array
	function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] num);
		if (num == '0)
			return '0;
		if (writeEn && writeNum == num)
			return writeData;
		return regs[num];
	endfunction

	always_ff @(posedge clk) begin
		if (writeEn && writeNum != '0)
			regs[writeNum] <= writeData;
	end

	assign dataA = readPort(readA);
	assign dataB = readPort(readB);

endmodule

`default_nettype wire

// File: src/execUnit.sv
`timescale 1ns/1ns
`default_nettype none

module execUnit (
	input  logic clk,
	input  logic reset,
	input  mipsPkg::instrWord decInstr,
	input  logic [mipsPkg::dataWidth-1:0] decPc,
	input  logic decValid,
	input  logic wbRegWrite,
	input  logic [mipsPkg::regAddrWidth-1:0] wbRegNum,
	input  logic [mipsPkg::dataWidth-1:0] wbRegData,
	output logic stall,
	output logic redirect,
	output logic [mipsPkg::dataWidth-1:0] target,
	exMemIf.exec exMem
);
	import mipsPkg::*;

	// decode stage
	logic [regAddrWidth-1:0] decRs;
	logic [regAddrWidth-1:0] decRt;
	logic [regAddrWidth-1:0] decWriteReg;
	logic [dataWidth-1:0] decRsVal;
	logic [dataWidth-1:0] decRtVal;
	logic [dataWidth-1:0] decImm;
	logic [aluCtrlWidth-1:0] decAluCtrl;
	logic decRegWrite;
	logic decMemToReg;
	logic decMemWrite;
	logic decByteMode;
	logic decAluSrc;
	logic decBranch;

	// execute stage
	logic [regAddrWidth-1:0] exRs;
	logic [regAddrWidth-1:0] exRt;
	logic [regAddrWidth-1:0] exWriteReg;
	logic [dataWidth-1:0] exRsVal;
	logic [dataWidth-1:0] exRtVal;
	logic [dataWidth-1:0] exImm;
	logic [dataWidth-1:0] exPc;
	logic [aluCtrlWidth-1:0] exAluCtrl;
	logic exRegWrite;
	logic exMemToReg;
	logic exMemWrite;
	logic exByteMode;
	logic exAluSrc;
	logic exBranch;
	logic [dataWidth-1:0] fwdA;
	logic [dataWidth-1:0] fwdB;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluOut;

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	// register fields read through the R view
	assign decRs = decInstr.rForm.rs;
	assign decRt = decInstr.rForm.rt;
	// sign extended immediate from the I view
	assign decImm = {{(dataWidth-16){decInstr.iForm.imm[15]}}, decInstr.iForm.imm};

	always_comb begin
		decRegWrite = 1'b0;
		decMemToReg = 1'b0;
		decMemWrite = 1'b0;
		decByteMode = 1'b0;
		decAluSrc = 1'b1;
		decBranch = 1'b0;
		decAluCtrl = aluAdd;
		decWriteReg = decInstr.iForm.rt;
		case (decInstr.iForm.op)
			opRType: begin
				decAluSrc = 1'b0;
				decWriteReg = decInstr.rForm.rd;
				decRegWrite = 1'b1;
				case (decInstr.rForm.funct)
					functAddu: decAluCtrl = aluAdd;
					functSubu: decAluCtrl = aluSub;
					functAnd: decAluCtrl = aluAnd;
					functOr: decAluCtrl = aluOr;
					functSlt: decAluCtrl = aluSlt;
					// unsupported funct acts as a nop
					default: decRegWrite = 1'b0;
				endcase
			end
			opAddiu: decRegWrite = 1'b1;
			opLw: begin
				decRegWrite = 1'b1;
				decMemToReg = 1'b1;
			end
			opLbu: begin
				decRegWrite = 1'b1;
				decMemToReg = 1'b1;
				decByteMode = 1'b1;
			end
			opSw: decMemWrite = 1'b1;
			opSb: begin
				decMemWrite = 1'b1;
				decByteMode = 1'b1;
			end
			opBeq: begin
				decAluSrc = 1'b0;
				decBranch = 1'b1;
			end
			default: ;
		endcase
		// empty slot and writes to $0 do nothing
		decRegWrite = decRegWrite & decValid & (decWriteReg != '0);
		decMemToReg = decMemToReg & decValid;
		decMemWrite = decMemWrite & decValid;
		decBranch = decBranch & decValid;
	end

	regFile regFile_i (
		.clk(clk),
		.readA(decRs),
		.readB(decRt),
		.dataA(decRsVal),
		.dataB(decRtVal),
		.writeEn(wbRegWrite),
		.writeNum(wbRegNum),
		.writeData(wbRegData)
	);

	// load in execute feeding the word in decode
	assign stall = exRegWrite && exMemToReg && (exWriteReg == decRs || exWriteReg == decRt);

	////////////////////////////////////////////////////////////////////////////
	// decode to execute register
	////////////////////////////////////////////////////////////////////////////

	// bubble on load-use or on a taken branch
	always_ff @(posedge clk) begin
		if (reset || stall || redirect) begin
			exRegWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exMemWrite <= 1'b0;
			exBranch <= 1'b0;
		end else begin
			exRegWrite <= decRegWrite;
			exMemToReg <= decMemToReg;
			exMemWrite <= decMemWrite;
			exBranch <= decBranch;
		end
	end

	always_ff @(posedge clk) begin
		exRs <= decRs;
		exRt <= decRt;
		exWriteReg <= decWriteReg;
		exRsVal <= decRsVal;
		exRtVal <= decRtVal;
		exImm <= decImm;
		exPc <= decPc;
		exAluCtrl <= decAluCtrl;
		exByteMode <= decByteMode;
		exAluSrc <= decAluSrc;
	end

	////////////////////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////////////////////

	// memory stage has priority, it is the younger result
	function automatic logic [dataWidth-1:0] forwardOperand(
		input logic [regAddrWidth-1:0] num,
		input logic [dataWidth-1:0] regVal
	);
		if (exMem.regWrite && exMem.writeReg == num)
			return exMem.aluOut;
		if (wbRegWrite && wbRegNum == num)
			return wbRegData;
		return regVal;
	endfunction

	assign fwdA = forwardOperand(exRs, exRsVal);
	assign fwdB = forwardOperand(exRt, exRtVal);
	assign aluB = exAluSrc ? exImm : fwdB;

	always_comb begin
		case (exAluCtrl)
			aluSub: aluOut = fwdA - aluB;
			aluAnd: aluOut = fwdA & aluB;
			aluOr: aluOut = fwdA | aluB;
			aluSlt: aluOut = {{(dataWidth-1){1'b0}}, $signed(fwdA) < $signed(aluB)};
			default: aluOut = fwdA + aluB;
		endcase
	end

	// beq resolved here, target is pc + 4 + offset words
	assign redirect = exBranch && (fwdA == fwdB);
	assign target = exPc + dataWidth'(4) + {exImm[dataWidth-3:0], 2'b00};

	// execute to memory register
	always_ff @(posedge clk) begin
		if (reset) begin
			exMem.regWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
			exMem.memWrite <= 1'b0;
		end else begin
			exMem.regWrite <= exRegWrite;
			exMem.memToReg <= exMemToReg;
			exMem.memWrite <= exMemWrite;
		end
	end

	always_ff @(posedge clk) begin
		exMem.byteMode <= exByteMode;
		exMem.aluOut <= aluOut;
		exMem.storeData <= fwdB;
		exMem.writeReg <= exWriteReg;
		exMem.pc <= exPc;
	end

endmodule

`default_nettype wire

// File: src/memWriteback.sv
`timescale 1ns/1ns
`default_nettype none

module memWriteback (
	input  logic clk,
	input  logic reset,
	exMemIf.mem exMem,
	output logic [mipsPkg::dataWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWriteData,
	output logic [mipsPkg::dataWidth/8-1:0] byteEnable,
	output logic memWrite,
	input  logic [mipsPkg::dataWidth-1:0] memReadData,
	output logic [mipsPkg::dataWidth-1:0] wbPc,
	output logic wbRegWrite,
	output logic [mipsPkg::regAddrWidth-1:0] wbRegNum,
	output logic [mipsPkg::dataWidth-1:0] wbRegData
);
	import mipsPkg::*;

	logic wbMemToReg;
	logic wbByteMode;
	logic [dataWidth-1:0] wbReadData;
	logic [dataWidth-1:0] wbAluOut;
	logic [7:0] wbLoadByte;

	////////////////////////////////////////////////////////////////////////////
	// memory stage
	////////////////////////////////////////////////////////////////////////////

	assign memAddr = exMem.aluOut;
	assign memWrite = exMem.memWrite;

	// sb drives one lane, byte copied to all lanes
	always_comb begin
		if (exMem.byteMode) begin
			byteEnable = 4'b0001 << exMem.aluOut[1:0];
			memWriteData = {(dataWidth/8){exMem.storeData[7:0]}};
		end else begin
			byteEnable = '1;
			memWriteData = exMem.storeData;
		end
	end

	// memory to write-back register
	always_ff @(posedge clk) begin
		if (reset) begin
			wbRegWrite <= 1'b0;
			wbMemToReg <= 1'b0;
		end else begin
			wbRegWrite <= exMem.regWrite;
			wbMemToReg <= exMem.memToReg;
		end
	end

	always_ff @(posedge clk) begin
		wbByteMode <= exMem.byteMode;
		wbReadData <= memReadData;
		wbAluOut <= exMem.aluOut;
		wbRegNum <= exMem.writeReg;
		wbPc <= exMem.pc;
	end

	////////////////////////////////////////////////////////////////////////////
	// write-back
	////////////////////////////////////////////////////////////////////////////

	// lbu lane picked by low address bits
	assign wbLoadByte = wbReadData[8 * wbAluOut[1:0] +: 8];

	always_comb begin
		if (!wbMemToReg)
			wbRegData = wbAluOut;
		else if (wbByteMode)
			wbRegData = {{(dataWidth-8){1'b0}}, wbLoadByte};
		else
			wbRegData = wbReadData;
	end

endmodule

`default_nettype wire

// File: src/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
	input  logic clk,
	input  logic reset,
	// instruction memory
	output logic [mipsPkg::dataWidth-1:0] pc,
	input  logic [mipsPkg::dataWidth-1:0] instr,
	// data memory
	output logic [mipsPkg::dataWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWriteData,
	output logic [mipsPkg::dataWidth/8-1:0] byteEnable,
	output logic memWrite,
	input  logic [mipsPkg::dataWidth-1:0] memReadData,
	// write-back debug
	output logic [mipsPkg::dataWidth-1:0] wbPc,
	output logic wbRegWrite,
	output logic [mipsPkg::regAddrWidth-1:0] wbRegNum,
	output logic [mipsPkg::dataWidth-1:0] wbRegData
);
	import mipsPkg::*;

	// fetch and decode handoff
	instrWord decInstr;
	logic [dataWidth-1:0] decPc;
	logic decValid;
	// hazard and branch feedback
	logic stall;
	logic redirect;
	logic [dataWidth-1:0] target;

	exMemIf exMemBus ();

	instrFetch instrFetch_i (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.pc(pc),
		.instr(instr),
		.decInstr(decInstr),
		.decPc(decPc),
		.decValid(decValid)
	);

	execUnit execUnit_i (
		.clk(clk),
		.reset(reset),
		.decInstr(decInstr),
		.decPc(decPc),
		.decValid(decValid),
		.wbRegWrite(wbRegWrite),
		.wbRegNum(wbRegNum),
		.wbRegData(wbRegData),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.exMem(exMemBus.exec)
	);

	memWriteback memWriteback_i (
		.clk(clk),
		.reset(reset),
		.exMem(exMemBus.mem),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.byteEnable(byteEnable),
		.memWrite(memWrite),
		.memReadData(memReadData),
		.wbPc(wbPc),
		.wbRegWrite(wbRegWrite),
		.wbRegNum(wbRegNum),
		.wbRegData(wbRegData)
	);

endmodule

`default_nettype wire

// File: sim/mipsCore_chk.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore_chk (
	input  logic clk,
	input  logic reset,
	input  logic [mipsPkg::dataWidth-1:0] pc,
	input  logic memWrite,
	input  logic [mipsPkg::dataWidth/8-1:0] byteEnable,
	input  logic wbRegWrite,
	input  logic [mipsPkg::regAddrWidth-1:0] wbRegNum
);

	// failed assertions so far
	int unsigned violations = 0;

	// a store always names a lane
	storeLanes: assert property (@(posedge clk) disable iff (reset)
		memWrite |-> byteEnable != '0)
	else begin
		violations = violations + 1;
		$error("store with no byte enable");
	end

	// writes to r0 are dropped at decode
	wbNonZero: assert property (@(posedge clk) disable iff (reset)
		wbRegWrite |-> wbRegNum != '0)
	else begin
		violations = violations + 1;
		$error("write-back to register zero");
	end

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
	else begin
		violations = violations + 1;
		$error("fetch address not word aligned");
	end

	// quiet once reset has been seen at an edge
	resetQuiet: assert property (@(posedge clk)
		reset && $past(reset) |-> !wbRegWrite && !memWrite)
	else begin
		violations = violations + 1;
		$error("write-back or store during reset");
	end

endmodule

bind mipsCore mipsCore_chk portCheck (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.memWrite(memWrite),
	.byteEnable(byteEnable),
	.wbRegWrite(wbRegWrite),
	.wbRegNum(wbRegNum)
);

`default_nettype wire

// File: sim/mipsCore_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore_tb;
	import mipsPkg::*;

	// expected write-back and store events, in program order
	typedef struct packed {
		logic [dataWidth-1:0] pc;
		logic [regAddrWidth-1:0] num;
		logic [dataWidth-1:0] data;
	} wbEvent;

	typedef struct packed {
		logic [dataWidth-1:0] addr;
		logic [dataWidth/8-1:0] lanes;
		logic [dataWidth-1:0] data;
	} storeEvent;

	logic clk;
	logic reset;
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] instr;
	logic [dataWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWriteData;
	logic [dataWidth/8-1:0] byteEnable;
	logic memWrite;
	logic [dataWidth-1:0] memReadData;
	logic [dataWidth-1:0] wbPc;
	logic wbRegWrite;
	logic [regAddrWidth-1:0] wbRegNum;
	logic [dataWidth-1:0] wbRegData;

	// 1 KB each, word indexed
	logic [dataWidth-1:0] progMem [256];
	logic [dataWidth-1:0] dataMem [256];
	logic [dataWidth-1:0] laneMask;

	wbEvent wbExpected [$];
	storeEvent stExpected [$];

	mipsCore mipsCore_i (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.byteEnable(byteEnable),
		.memWrite(memWrite),
		.memReadData(memReadData),
		.wbPc(wbPc),
		.wbRegWrite(wbRegWrite),
		.wbRegNum(wbRegNum),
		.wbRegData(wbRegData)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// memory models
	////////////////////////////////////////////////////////////////////////////

	// nop beyond the program area
	assign instr = (pc[dataWidth-1:10] == '0) ? progMem[pc[9:2]] : '0;
	assign memReadData = dataMem[memAddr[9:2]];

	// byte enables widened to bit lanes
	assign laneMask = {{8{byteEnable[3]}}, {8{byteEnable[2]}},
		{8{byteEnable[1]}}, {8{byteEnable[0]}}};

	// write commits at the rising edge
	always @(posedge clk) begin
		if (memWrite === 1'b1)
			dataMem[memAddr[9:2]] <= (dataMem[memAddr[9:2]] & ~laneMask) | (memWriteData & laneMask);
	end

	////////////////////////////////////////////////////////////////////////////
	// reporting and compares
	////////////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(input string name, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] exp);
		abortRun($sformatf("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic comparePc(input logic [dataWidth-1:0] got, input logic [dataWidth-1:0] exp);
		if (got !== exp)
			reportMismatch("pc", got, exp);
	endtask

	task automatic compareWriteBack(input logic [dataWidth-1:0] gotPc,
		input logic [regAddrWidth-1:0] gotNum, input logic [dataWidth-1:0] gotData,
		input wbEvent exp);
		if (gotPc !== exp.pc)
			reportMismatch("wbPc", gotPc, exp.pc);
		else if (gotNum !== exp.num)
			reportMismatch("wbRegNum", dataWidth'(gotNum), dataWidth'(exp.num));
		else if (gotData !== exp.data)
			reportMismatch("wbRegData", gotData, exp.data);
	endtask

	task automatic compareStore(input logic [dataWidth-1:0] gotAddr,
		input logic [dataWidth/8-1:0] gotLanes, input logic [dataWidth-1:0] gotData,
		input storeEvent exp);
		if (gotAddr !== exp.addr)
			reportMismatch("memAddr", gotAddr, exp.addr);
		else if (gotLanes !== exp.lanes)
			reportMismatch("byteEnable", dataWidth'(gotLanes), dataWidth'(exp.lanes));
		else if (gotData !== exp.data)
			reportMismatch("memWriteData", gotData, exp.data);
	endtask

	// program, data and expected events from one tagged file
	task automatic loadTests();
		int fd;
		string line;
		logic [7:0] tag;
		logic [dataWidth-1:0] f1;
		logic [dataWidth-1:0] f2;
		logic [dataWidth-1:0] f3;
		logic [7:0] progCount;
		progCount = '0;
		for (int i = 0; i < 256; i++) begin
			progMem[8'(i)] = '0;
			// fill follows the word index
			dataMem[8'(i)] = {4{8'(i)}} ^ 32'h5a3c_96e1;
		end
		fd = $fopen("sim/mipsCore_tests.txt", "r");
		if (fd == 0)
			abortRun("could not open sim/mipsCore_tests.txt");
		else begin
			while ($fgets(line, fd) != 0) begin
				void'($sscanf(line, "%c %h %h %h", tag, f1, f2, f3));
				case (tag)
					"I": begin
						progMem[progCount] = f1;
						progCount = progCount + 8'd1;
					end
					"D": dataMem[f1[9:2]] = f2;
					"W": wbExpected.push_back('{pc: f1, num: f2[regAddrWidth-1:0], data: f3});
					"S": stExpected.push_back('{addr: f1, lanes: f2[dataWidth/8-1:0], data: f3});
					// comments and blank lines
					default: ;
				endcase
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitors, sampled before the edge updates them
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (wbRegWrite === 1'b1) begin
			if (wbExpected.size() == 0)
				abortRun($sformatf("unexpected write-back to r%0d from pc %h", wbRegNum, wbPc));
			else
				compareWriteBack(wbPc, wbRegNum, wbRegData, wbExpected.pop_front());
		end
	end

	always @(posedge clk) begin
		if (memWrite === 1'b1) begin
			if (stExpected.size() == 0)
				abortRun($sformatf("unexpected store to address %h", memAddr));
			else
				compareStore(memAddr, byteEnable, memWriteData, stExpected.pop_front());
		end
	end

	// any port assertion failure ends the run at once
	always @(mipsCore_i.portCheck.violations) begin
		if (mipsCore_i.portCheck.violations != 0)
			abortRun("a port assertion failed, see the error above");
	end

	initial begin
		int cycles;
		clk = 1'b0;
		reset = 1'b1;
		loadTests();
		repeat (4) @(negedge clk);
		reset = 1'b0;
		// first fetch from the reset vector
		comparePc(pc, resetPc);
		cycles = 0;
		// program is about 40 words, 300 cycles is ample
		while ((wbExpected.size() != 0 || stExpected.size() != 0) && cycles < 300) begin
			@(negedge clk);
			cycles++;
		end
		if (wbExpected.size() != 0 || stExpected.size() != 0)
			abortRun($sformatf("timeout after %0d cycles, %0d write-backs and %0d stores missing",
				cycles, wbExpected.size(), stExpected.size()));
		else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: sim/mipsCore_tests.txt
# all fields hex: I word | D addr word | W pc reg value | S addr byteEnable data
# I words load from address 0 in order, W and S are checked in order
I 24010005
I 2402fffd
I 00221821
I 00612023
I 00812824
I 00a33025
I 0086382a
I 00c4402a
I 24e90100
I 240a0040
I 8d4b0000
I 01666021
I 8d4d0004
I 002d7023
I a1410010
I a1460011
I a14b0012
I a1420013
I 914f0012
I 91500013
I ad4c0020
I 91510021
I 02309021
I 8d530010
I 10820003
I 24140001
I ad410000
I 24150002
I 24160033
I 10260005
I 02c1b821
I 24000055
I 0001c021
D 00000040 11223344
D 00000044 80000010
W 00000000 01 00000005
W 00000004 02 fffffffd
W 00000008 03 00000002
W 0000000c 04 fffffffd
W 00000010 05 00000005
W 00000014 06 00000007
W 00000018 07 00000001
W 0000001c 08 00000000
W 00000020 09 00000101
W 00000024 0a 00000040
W 00000028 0b 11223344
W 0000002c 0c 1122334b
W 00000030 0d 80000010
W 00000034 0e 7ffffff5
S 00000050 1 05050505
S 00000051 2 07070707
S 00000052 4 44444444
S 00000053 8 fdfdfdfd
W 00000048 0f 00000044
W 0000004c 10 000000fd
S 00000060 f 1122334b
W 00000054 11 00000033
W 00000058 12 00000130
W 0000005c 13 fd440705
# beq at 60 is taken, 64 and 68 flushed, 6c skipped
W 00000070 16 00000033
W 00000078 17 00000038
W 00000080 18 00000005

// File: vlog.f
src/mipsPkg.sv
src/exMemIf.sv
src/instrFetch.sv
src/regFile.sv
src/execUnit.sv
src/memWriteback.sv
src/mipsCore.sv
sim/mipsCore_chk.sv
sim/mipsCore_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mipsCore_tb -Mdir obj_dir -f vlog.f
out=$(./obj_dir/VmipsCore_tb +verilator+error+limit+1000 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "all tests passed"
